//--- hw/armCtrlPkg.sv
package armCtrlPkg;

  // Stored and ALU flags share this order
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  typedef enum logic [1:0] {
    ALU_ADD = 2'b00,
    ALU_SUB = 2'b01,
    ALU_AND = 2'b10,
    ALU_ORR = 2'b11
  } aluCtrlE;

  typedef enum logic [3:0] {
    EQ, NE, CS, CC, MI, PL, VS, VC,
    HI, LS, GE, LT, GT, LE, AL, NV
  } condE;

  // Instruction bits 24..21
  typedef enum logic [3:0] {
    FN_AND = 4'b0000,
    FN_SUB = 4'b0010,
    FN_ADD = 4'b0100,
    FN_ORR = 4'b1100
  } dpFuncE;

  typedef struct packed {
    logic nz;                        // N and Z update
    logic cv;                        // C and V update
  } flagWriteT;

  typedef struct packed {
    logic [1:0] regSrc;
    logic [1:0] immSrc;
  } decodeOutT;

  typedef struct packed {
    flagWriteT flagWrite;
    logic      branch;
    logic      memWrite;
    logic      regWrite;
    logic      pcSrc;
    logic      memtoReg;
    logic      aluSrc;
    aluCtrlE   aluControl;
    condE      cond;
  } execCtrlT;

  typedef struct packed {
    logic    aluSrc;
    aluCtrlE aluControl;
    logic    memtoReg;
    logic    branchTaken;
  } execOutT;

  typedef struct packed {
    logic memWrite;
    logic memtoReg;
    logic regWrite;
    logic pcSrc;
  } memCtrlT;

  typedef struct packed {
    logic memtoReg;
    logic regWrite;
    logic pcSrc;
  } wbOutT;

  // regSrc, immSrc, aluSrc, memtoReg, regWrite, memWrite, branch, aluOp
  localparam logic [9:0] CTRL_DP_IMM = 10'b00_00_1_0_1_0_0_1;
  localparam logic [9:0] CTRL_DP_REG = 10'b00_00_0_0_1_0_0_1;
  localparam logic [9:0] CTRL_LDR    = 10'b00_01_1_1_1_0_0_0;
  localparam logic [9:0] CTRL_STR    = 10'b10_01_1_1_0_1_0_0;
  localparam logic [9:0] CTRL_BR     = 10'b01_10_1_0_0_0_1_0;
  localparam logic [9:0] CTRL_NOP    = 10'b00_00_0_0_0_0_0_0;

  localparam logic [3:0] PC_REG = 4'd15;

  // Bubble loaded into execute on a flush
  localparam execCtrlT EXEC_FLUSH = '{
    flagWrite:  '{nz: 1'b0, cv: 1'b0},
    branch:     1'b0,
    memWrite:   1'b0,
    regWrite:   1'b0,
    pcSrc:      1'b0,
    memtoReg:   1'b0,
    aluSrc:     1'b0,
    aluControl: ALU_ADD,
    cond:       AL
  };

endpackage

//--- hw/ctrlDecode.sv
`timescale 1ns/10ps

module ctrlDecode
  import armCtrlPkg::*;
(
  input  logic [31:12] instrD,
  output decodeOutT    decOut,
  output execCtrlT     ctrlD,
  output logic         pcSrcD
);

  logic [9:0] controls;
  logic [1:0] regSrc;
  logic [1:0] immSrc;
  logic       aluSrc;
  logic       memtoReg;
  logic       regWriteRaw;
  logic       regWrite;
  logic       memWrite;
  logic       branch;
  logic       aluOp;
  logic       funcKnown;
  logic [3:0] rd;
  dpFuncE     func;
  aluCtrlE    aluControl;
  flagWriteT  flagWrite;

  assign func = dpFuncE'(instrD[24:21]);
  assign rd   = instrD[15:12];

  // Main decoder
  always_comb begin
    case (instrD[27:26])
      2'b00:   controls = instrD[25] ? CTRL_DP_IMM : CTRL_DP_REG;
      2'b01:   controls = instrD[20] ? CTRL_LDR : CTRL_STR;   // L bit picks load
      2'b10:   controls = CTRL_BR;
      default: controls = CTRL_NOP;                           // Op 11 does nothing
    endcase
  end

  assign {regSrc, immSrc, aluSrc, memtoReg, regWriteRaw, memWrite, branch, aluOp} = controls;

  // ALU decoder
  always_comb begin
    aluControl = ALU_ADD;                    // Address add for memory and branch
    funcKnown  = 1'b1;
    flagWrite  = '{nz: 1'b0, cv: 1'b0};
    if (aluOp) begin
      case (func)
        FN_ADD:  aluControl = ALU_ADD;
        FN_SUB:  aluControl = ALU_SUB;
        FN_AND:  aluControl = ALU_AND;
        FN_ORR:  aluControl = ALU_ORR;
        default: funcKnown  = 1'b0;
      endcase
      flagWrite.nz = instrD[20] & funcKnown;                       // S bit
      flagWrite.cv = instrD[20] & ((func == FN_ADD) | (func == FN_SUB));
    end
  end

  assign regWrite = regWriteRaw & funcKnown;
  assign pcSrcD   = (regWrite & (rd == PC_REG)) | branch;

  assign decOut = '{regSrc: regSrc, immSrc: immSrc};

  assign ctrlD = '{
    flagWrite:  flagWrite,
    branch:     branch,
    memWrite:   memWrite,
    regWrite:   regWrite,
    pcSrc:      pcSrcD,
    memtoReg:   memtoReg,
    aluSrc:     aluSrc,
    aluControl: aluControl,
    cond:       condE'(instrD[31:28])
  };

endmodule

//--- hw/condCheck.sv
`timescale 1ns/10ps

module condCheck
  import armCtrlPkg::*;
(
  input  condE      cond,
  input  flagsT     flags,
  input  flagsT     aluFlags,
  input  flagWriteT flagWrite,
  output logic      condEx,
  output flagsT     flagsNext
);

  logic ge;
  logic hi;

  assign ge = (flags.n == flags.v);
  assign hi = flags.c & ~flags.z;

  always_comb begin
    case (cond)
      EQ:      condEx = flags.z;
      NE:      condEx = ~flags.z;
      CS:      condEx = flags.c;
      CC:      condEx = ~flags.c;
      MI:      condEx = flags.n;
      PL:      condEx = ~flags.n;
      VS:      condEx = flags.v;
      VC:      condEx = ~flags.v;
      HI:      condEx = hi;                  // Unsigned higher
      LS:      condEx = ~hi;
      GE:      condEx = ge;
      LT:      condEx = ~ge;
      GT:      condEx = ~flags.z & ge;
      LE:      condEx = ~(~flags.z & ge);
      AL:      condEx = 1'b1;
      default: condEx = 1'b0;                // NV never runs
    endcase
  end

  // A skipped instruction leaves the flags alone
  always_comb begin
    flagsNext = flags;
    if (flagWrite.nz && condEx) begin
      flagsNext.n = aluFlags.n;
      flagsNext.z = aluFlags.z;
    end
    if (flagWrite.cv && condEx) begin
      flagsNext.c = aluFlags.c;
      flagsNext.v = aluFlags.v;
    end
  end

endmodule

//--- hw/ctrlExecute.sv
`timescale 1ns/10ps

module ctrlExecute
  import armCtrlPkg::*;
(
  input  logic     clk,
  input  logic     rstN,
  input  logic     flushE,
  input  execCtrlT ctrlD,
  input  flagsT    aluFlagsE,
  output execOutT  exeOut,
  output memCtrlT  ctrlGatedE,
  output logic     pcSrcE
);

  execCtrlT ctrlE;
  flagsT    flagsE;
  flagsT    flagsNextE;
  logic     condExE;

  // Execute register including the condition field
  always_ff @(posedge clk) begin
    if (!rstN) begin
      ctrlE <= '0;
    end else if (flushE) begin
      ctrlE <= EXEC_FLUSH;                   // Bubble
    end else begin
      ctrlE <= ctrlD;
    end
  end

  // Architectural NZCV
  always_ff @(posedge clk) begin
    if (!rstN) begin
      flagsE <= '0;
    end else begin
      flagsE <= flagsNextE;
    end
  end

  condCheck u_condCheck (
    .cond      (ctrlE.cond),
    .flags     (flagsE),
    .aluFlags  (aluFlagsE),
    .flagWrite (ctrlE.flagWrite),
    .condEx    (condExE),
    .flagsNext (flagsNextE)
  );

  assign exeOut = '{
    aluSrc:      ctrlE.aluSrc,
    aluControl:  ctrlE.aluControl,
    memtoReg:    ctrlE.memtoReg,
    branchTaken: ctrlE.branch & condExE
  };

  assign ctrlGatedE = '{
    memWrite: ctrlE.memWrite & condExE,
    memtoReg: ctrlE.memtoReg,                // Harmless without regWrite
    regWrite: ctrlE.regWrite & condExE,
    pcSrc:    ctrlE.pcSrc & condExE
  };

  assign pcSrcE = ctrlE.pcSrc;               // Ungated, for hazard prediction

endmodule

//--- hw/ctrlResult.sv
`timescale 1ns/10ps

module ctrlResult
  import armCtrlPkg::*;
(
  input  logic    clk,
  input  logic    rstN,
  input  memCtrlT ctrlGatedE,
  input  logic    pcSrcD,
  input  logic    pcSrcE,
  output memCtrlT memOut,
  output wbOutT   wbOut,
  output logic    pcWrPendingF
);

  // Memory stage
  always_ff @(posedge clk) begin
    if (!rstN) begin
      memOut <= '0;
    end else begin
      memOut <= ctrlGatedE;
    end
  end

  // Writeback stage drops the store enable
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wbOut <= '0;
    end else begin
      wbOut <= '{
        memtoReg: memOut.memtoReg,
        regWrite: memOut.regWrite,
        pcSrc:    memOut.pcSrc
      };
    end
  end

  // Any older PC write stalls fetch
  assign pcWrPendingF = pcSrcD | pcSrcE | memOut.pcSrc;

endmodule

//--- hw/pipeController.sv
`timescale 1ns/10ps

module pipeController
  import armCtrlPkg::*;
(
  input  logic         clk,
  input  logic         rstN,
  input  logic [31:12] instrD,
  input  flagsT        aluFlagsE,
  input  logic         flushE,       // From hazard unit
  output decodeOutT    decOut,
  output execOutT      exeOut,
  output memCtrlT      memOut,
  output wbOutT        wbOut,
  output logic         pcWrPendingF
);

  execCtrlT ctrlD;
  memCtrlT  ctrlGatedE;
  logic     pcSrcD;
  logic     pcSrcE;

  ctrlDecode u_decode (
    .instrD (instrD),
    .decOut (decOut),
    .ctrlD  (ctrlD),
    .pcSrcD (pcSrcD)
  );

  ctrlExecute u_execute (
    .clk        (clk),
    .rstN       (rstN),
    .flushE     (flushE),
    .ctrlD      (ctrlD),
    .aluFlagsE  (aluFlagsE),
    .exeOut     (exeOut),
    .ctrlGatedE (ctrlGatedE),
    .pcSrcE     (pcSrcE)
  );

  ctrlResult u_result (
    .clk          (clk),
    .rstN         (rstN),
    .ctrlGatedE   (ctrlGatedE),
    .pcSrcD       (pcSrcD),
    .pcSrcE       (pcSrcE),
    .memOut       (memOut),
    .wbOut        (wbOut),
    .pcWrPendingF (pcWrPendingF)
  );

endmodule

//--- tests/pipeController_assertions.sv
`timescale 1ns/10ps

module pipeController_assertions (
  input logic        clk,
  input logic        rstN,
  input logic        flushE,
  input logic        branchTaken,
  input logic        branchD,        // Branch entering execute
  input logic [2:0]  gatedWrites,    // memWrite, regWrite, pcSrc
  input logic [17:0] regState        // Registered state, zero padded
);

  // A bubble in execute writes nothing
  flushNoWrite: assert property (@(posedge clk) disable iff (!rstN)
    flushE |=> (gatedWrites == 3'b000))
    else $error("flushed execute stage produced a write");

  // Only an unflushed branch from decode can be taken
  branchHeldInExec: assert property (@(posedge clk) disable iff (!rstN)
    branchTaken |-> $past(branchD && !flushE))
    else $error("branch taken without a branch in execute");

  regsZeroInReset: assert property (@(posedge clk)
    !rstN |=> (regState == '0))
    else $error("registered state not cleared by reset");

endmodule

bind ctrlExecute pipeController_assertions u_execAsrt (
  .clk         (clk),
  .rstN        (rstN),
  .flushE      (flushE),
  .branchTaken (exeOut.branchTaken),
  .branchD     (ctrlD.branch),
  .gatedWrites ({ctrlGatedE.memWrite, ctrlGatedE.regWrite, ctrlGatedE.pcSrc}),
  .regState    ({ctrlE, flagsE})
);

bind ctrlResult pipeController_assertions u_resultAsrt (
  .clk         (clk),
  .rstN        (rstN),
  .flushE      (1'b0),
  .branchTaken (1'b0),
  .branchD     (1'b0),
  .gatedWrites (3'b000),
  .regState    ({11'd0, memOut, wbOut})
);

//--- tests/pipeControllerTb.sv
`timescale 1ns/10ps

module pipeControllerTb
  import armCtrlPkg::*;
();

  localparam int NUM_INSTR      = 2000;
  localparam int TIMEOUT_CYCLES = NUM_INSTR + 100;   // Reset, drain and margin

  logic         clk = 1'b0;
  logic         rstN;
  logic [31:12] instrD;
  flagsT        aluFlagsE;
  logic         flushE;
  decodeOutT    decOut;
  execOutT      exeOut;
  memCtrlT      memOut;
  wbOutT        wbOut;
  logic         pcWrPendingF;

  integer   seed;
  int       errorCount = 0;
  int       cycleCount = 0;
  bit       modelValid = 1'b0;
  execCtrlT expEx;                   // Instruction held in execute
  memCtrlT  expMem;
  wbOutT    expWb;
  flagsT    expFlags;

  pipeController u_dut (
    .clk          (clk),
    .rstN         (rstN),
    .instrD       (instrD),
    .aluFlagsE    (aluFlagsE),
    .flushE       (flushE),
    .decOut       (decOut),
    .exeOut       (exeOut),
    .memOut       (memOut),
    .wbOut        (wbOut),
    .pcWrPendingF (pcWrPendingF)
  );

  always #4 clk = ~clk;

  // Expected decode from the control table
  function automatic execCtrlT refDecode(input logic [31:12] instr, output decodeOutT dec);
    execCtrlT   ctrl;
    logic [3:0] fn;
    logic       known;
    ctrl = '0;
    dec = '0;
    fn = instr[24:21];
    ctrl.cond = condE'(instr[31:28]);
    ctrl.aluControl = ALU_ADD;
    case (instr[27:26])
      2'b00: begin
        known = 1'b1;
        case (fn)
          FN_ADD:  ctrl.aluControl = ALU_ADD;
          FN_SUB:  ctrl.aluControl = ALU_SUB;
          FN_AND:  ctrl.aluControl = ALU_AND;
          FN_ORR:  ctrl.aluControl = ALU_ORR;
          default: known = 1'b0;
        endcase
        ctrl.aluSrc = instr[25];
        ctrl.regWrite = known;
        ctrl.flagWrite.nz = instr[20] & known;
        ctrl.flagWrite.cv = instr[20] & ((fn == FN_ADD) || (fn == FN_SUB));
      end
      2'b01: begin
        dec.immSrc = 2'b01;
        ctrl.aluSrc = 1'b1;
        ctrl.memtoReg = 1'b1;
        ctrl.regWrite = instr[20];             // Load
        ctrl.memWrite = ~instr[20];            // Store
        dec.regSrc = instr[20] ? 2'b00 : 2'b10;
      end
      2'b10: begin
        dec = '{regSrc: 2'b01, immSrc: 2'b10};
        ctrl.aluSrc = 1'b1;
        ctrl.branch = 1'b1;
      end
      default: ;                               // Op 11 is a no-op
    endcase
    ctrl.pcSrc = (ctrl.regWrite && (instr[15:12] == 4'd15)) || ctrl.branch;
    return ctrl;
  endfunction

  function automatic logic refCond(input condE cond, input flagsT f);
    logic r;
    case (cond)
      EQ: r = f.z;
      NE: r = !f.z;
      CS: r = f.c;
      CC: r = !f.c;
      MI: r = f.n;
      PL: r = !f.n;
      VS: r = f.v;
      VC: r = !f.v;
      HI: r = f.c && !f.z;
      LS: r = !f.c || f.z;
      GE: r = (f.n == f.v);
      LT: r = (f.n != f.v);
      GT: r = !f.z && (f.n == f.v);
      LE: r = f.z || (f.n != f.v);
      AL: r = 1'b1;
      default: r = 1'b0;
    endcase
    return r;
  endfunction

  function automatic flagsT refFlags(input flagWriteT fw, input logic ex,
                                     input flagsT cur, input flagsT alu);
    flagsT f;
    f = cur;
    if (fw.nz && ex) {f.n, f.z} = {alu.n, alu.z};
    if (fw.cv && ex) {f.c, f.v} = {alu.c, alu.v};
    return f;
  endfunction

  task automatic reportMismatch(input string name, input logic [15:0] exp, input logic [15:0] got);
    errorCount++;
    $display("error at %0t: %s expected %h got %h", $time, name, exp, got);
    $display("tests failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic checkDecode(input decodeOutT got, input decodeOutT exp);
    if (got !== exp) reportMismatch("decOut", exp, got);
  endtask

  task automatic checkExec(input execOutT got, input execOutT exp);
    if (got !== exp) reportMismatch("exeOut", exp, got);
  endtask

  task automatic checkMem(input memCtrlT got, input memCtrlT exp);
    if (got !== exp) reportMismatch("memOut", exp, got);
  endtask

  task automatic checkWb(input wbOutT got, input wbOutT exp);
    if (got !== exp) reportMismatch("wbOut", exp, got);
  endtask

  task automatic checkPending(input logic got, input logic exp);
    if (got !== exp) reportMismatch("pcWrPendingF", exp, got);
  endtask

  // Pipeline and flags model
  always @(posedge clk) begin : modelUpdate
    decodeOutT unusedDec;
    logic      ex;
    if (!rstN) begin
      expEx = '0;
      expMem = '0;
      expWb = '0;
      expFlags = '0;
    end else begin
      ex = refCond(expEx.cond, expFlags);
      expWb = '{memtoReg: expMem.memtoReg, regWrite: expMem.regWrite, pcSrc: expMem.pcSrc};
      expMem = '{memWrite: expEx.memWrite & ex, memtoReg: expEx.memtoReg,
                 regWrite: expEx.regWrite & ex, pcSrc: expEx.pcSrc & ex};
      expFlags = refFlags(expEx.flagWrite, ex, expFlags, aluFlagsE);
      if (flushE) begin
        expEx = '0;
        expEx.cond = AL;                       // Bubble
      end else begin
        expEx = refDecode(instrD, unusedDec);
      end
    end
    modelValid = 1'b1;
  end

  always @(negedge clk) begin : compare
    decodeOutT expDec;
    execCtrlT  ctrlNow;
    execOutT   expOut;
    if (modelValid) begin
      ctrlNow = refDecode(instrD, expDec);
      expOut = '{aluSrc: expEx.aluSrc, aluControl: expEx.aluControl, memtoReg: expEx.memtoReg,
                 branchTaken: expEx.branch & refCond(expEx.cond, expFlags)};
      checkDecode(decOut, expDec);
      checkExec(exeOut, expOut);
      checkMem(memOut, expMem);
      checkWb(wbOut, expWb);
      checkPending(pcWrPendingF, ctrlNow.pcSrc | expEx.pcSrc | expMem.pcSrc);
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("tests failed");
      $fatal(1, "stopped on timeout");
    end
  end

  task automatic driveRandom();
    logic [31:0] r;
    logic [31:0] f;
    int unsigned cls;
    r = $random(seed);
    f = $random(seed);
    cls = $unsigned($random(seed)) % 6;
    case (cls)
      0, 1: begin
        r[27:25] = {2'b00, cls == 0};          // Immediate or register
        case ($unsigned($random(seed)) % 5)
          0: r[24:21] = FN_ADD;
          1: r[24:21] = FN_SUB;
          2: r[24:21] = FN_AND;
          3: r[24:21] = FN_ORR;
          default: ;                           // Mostly unknown functions
        endcase
      end
      2: {r[27:26], r[20]} = 3'b011;           // LDR
      3: {r[27:26], r[20]} = 3'b010;           // STR
      4: r[27:26] = 2'b10;
      default: r[27:26] = 2'b11;
    endcase
    if ($unsigned($random(seed)) % 4 == 0) r[15:12] = 4'd15;
    instrD = r[31:12];
    aluFlagsE = f[3:0];
    flushE = ($unsigned($random(seed)) % 8) == 0;
  endtask

  initial begin
    seed = 32'hc7634865;
    rstN = 1'b0;
    instrD = '0;
    aluFlagsE = '0;
    flushE = 1'b0;
    repeat (8) @(posedge clk);
    for (int i = 0; i < NUM_INSTR; i++) begin
      #1;
      rstN = 1'b1;
      driveRandom();
      @(posedge clk);
    end
    repeat (4) @(posedge clk);                 // Drain writeback
    #2;
    if (errorCount == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- flist.f
hw/armCtrlPkg.sv
hw/ctrlDecode.sv
hw/condCheck.sv
hw/ctrlExecute.sv
hw/ctrlResult.sv
hw/pipeController.sv
tests/pipeController_assertions.sv
tests/pipeControllerTb.sv

//--- Bender.yml
package:
  name: pipe_controller

sources:
  - hw/armCtrlPkg.sv
  - hw/ctrlDecode.sv
  - hw/condCheck.sv
  - hw/ctrlExecute.sv
  - hw/ctrlResult.sv
  - hw/pipeController.sv
  - target: test
    files:
      - tests/pipeController_assertions.sv
      - tests/pipeControllerTb.sv
